//--- logic/usbmem_consts.svh
// usb memory subsystem constants.
// memory geometry, host region decode and instruction field widths.
`ifndef USBMEM_CONSTS_SVH
`define USBMEM_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define USBMEM_PMEM_AW    10  // program memory word address width.
`define USBMEM_PMEM_DW    16  // one instruction per program word.
`define USBMEM_DMEM_AW    12  // data memory byte address width.
`define USBMEM_DMEM_WAW   10  // data memory word address width.
`define USBMEM_LANES      4   // byte lanes per host word.
`define USBMEM_BYTE_W     8
`define USBMEM_HOST_DW    32

`define USBMEM_REGION_BIT 17  // set selects data memory, clear selects program memory.

// instruction layout, opcode on top of a shared address or immediate field.
`define USBMEM_OP_W       4
`define USBMEM_FIELD_W    12
`define USBMEM_IMM_W      8   // immediate sits in the low bits of the field.

`endif

//--- logic/usbmem_pkg.sv
// types shared by the usb memory subsystem.
// engine opcodes and states, instruction word and host bus request.
`include "usbmem_consts.svh"

package usbmem_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sequencer encodings
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [`USBMEM_OP_W-1:0] {
		OP_NOP  = 4'h0,
		OP_LDI  = 4'h1,  // acc takes the immediate.
		OP_LD   = 4'h2,  // acc takes the addressed byte.
		OP_ST   = 4'h3,  // addressed byte takes acc.
		OP_ADD  = 4'h4,  // acc plus addressed byte, wrapping at 256.
		OP_JMP  = 4'h5,
		OP_HALT = 4'h6
	} opcode_e;

	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		DECODE,
		EXECUTE,
		HALTED
	} seq_state_e;

	typedef struct packed {
		opcode_e                    opcode;
		logic [`USBMEM_FIELD_W-1:0] field;  // byte address, or immediate in the low byte.
	} insn_t;

	// strobe/acknowledge host bus, all fields held until acknowledge.
	typedef struct packed {
		logic                       stb;
		logic                       we;
		logic [`USBMEM_LANES-1:0]   sel;  // sel[3] covers bits 31..24, byte address 4w.
		logic [31:0]                adr;
		logic [`USBMEM_HOST_DW-1:0] wdata;
	} host_req_t;

endpackage

//--- logic/dual_port_ram.sv
// two port synchronous RAM.
// both ports read and write, reads are registered and return the old word on a write.
module dual_port_ram #(
	parameter int ADDR_W = 10,
	parameter int DATA_W = 8
) (
	input  logic              sys_clk,

	input  logic [ADDR_W-1:0] a_addr_i,
	input  logic              a_we_i,
	input  logic [DATA_W-1:0] a_wdata_i,
	output logic [DATA_W-1:0] a_rdata_o,

	input  logic [ADDR_W-1:0] b_addr_i,
	input  logic              b_we_i,
	input  logic [DATA_W-1:0] b_wdata_i,
	output logic [DATA_W-1:0] b_rdata_o
);

	logic [DATA_W-1:0] mem [0:(1 << ADDR_W) - 1];

	// one process owns the array, so both ports update it here.
	// two writes to the same word in one cycle leave it undefined.
	always_ff @(posedge sys_clk) begin
		if (a_we_i) begin
			mem[a_addr_i] <= a_wdata_i;
		end
		if (b_we_i) begin
			mem[b_addr_i] <= b_wdata_i;
		end
		a_rdata_o <= mem[a_addr_i];  // read first.
		b_rdata_o <= mem[b_addr_i];
	end

endmodule

//--- logic/shared_ram.sv
// shared RAM between the host bus and the byte engine.
// program memory plus four data byte lanes, host word access and engine byte access.
`include "usbmem_consts.svh"

module shared_ram (
	input  logic                        sys_clk,
	input  logic                        sys_rst,

	input  usbmem_pkg::host_req_t       host_req_i,
	output logic                        host_ack_o,
	output logic [`USBMEM_HOST_DW-1:0]  host_rdata_o,

	input  logic [`USBMEM_PMEM_AW-1:0]  pmem_addr_i,
	output usbmem_pkg::insn_t           pmem_data_o,

	input  logic [`USBMEM_DMEM_AW-1:0]  dmem_addr_i,
	input  logic                        dmem_we_i,
	input  logic [`USBMEM_BYTE_W-1:0]   dmem_wdata_i,
	output logic [`USBMEM_BYTE_W-1:0]   dmem_rdata_o
);

	logic                                         host_wr_first;
	logic                                         region_data;
	logic [`USBMEM_DMEM_WAW-1:0]                  host_word;
	logic [`USBMEM_PMEM_DW-1:0]                   prog_rdata;
	logic [`USBMEM_LANES-1:0][`USBMEM_BYTE_W-1:0] lane_rdata;
	logic [`USBMEM_LANES-1:0][`USBMEM_BYTE_W-1:0] lane_eng_rdata;
	logic                                         region_q;
	logic [1:0]                                   lane_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// host bus decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign region_data   = host_req_i.adr[`USBMEM_REGION_BIT];
	assign host_word     = host_req_i.adr[`USBMEM_DMEM_AW-1:2];
	assign host_wr_first = host_req_i.stb & host_req_i.we & ~host_ack_o;  // only the first edge writes.

	// the acknowledge is fed back so a held strobe never gets two in a row.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			host_ack_o <= 1'b0;
		end else begin
			host_ack_o <= host_req_i.stb & ~host_ack_o;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// program memory, read only from the engine side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	dual_port_ram #(
		.ADDR_W (`USBMEM_PMEM_AW),
		.DATA_W (`USBMEM_PMEM_DW)
	) u_pmem (
		.sys_clk   (sys_clk),
		.a_addr_i  (host_req_i.adr[`USBMEM_PMEM_AW+1:2]),
		.a_we_i    (host_wr_first & ~region_data),
		.a_wdata_i (host_req_i.wdata[`USBMEM_PMEM_DW-1:0]),
		.a_rdata_o (prog_rdata),
		.b_addr_i  (pmem_addr_i),
		.b_we_i    (1'b0),
		.b_wdata_i ('0),
		.b_rdata_o (pmem_data_o)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// data memory lanes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// lane i holds host bits 8i+7..8i, which is engine byte offset 3-i.
	for (genvar i = 0; i < `USBMEM_LANES; i++) begin : g_lane
		dual_port_ram #(
			.ADDR_W (`USBMEM_DMEM_WAW),
			.DATA_W (`USBMEM_BYTE_W)
		) u_lane (
			.sys_clk   (sys_clk),
			.a_addr_i  (host_word),
			.a_we_i    (host_wr_first & region_data & host_req_i.sel[i]),
			.a_wdata_i (host_req_i.wdata[`USBMEM_BYTE_W*i +: `USBMEM_BYTE_W]),
			.a_rdata_o (lane_rdata[i]),
			.b_addr_i  (dmem_addr_i[`USBMEM_DMEM_AW-1:2]),
			.b_we_i    (dmem_we_i & (dmem_addr_i[1:0] == 2'(3 - i))),
			.b_wdata_i (dmem_wdata_i),
			.b_rdata_o (lane_eng_rdata[i])
		);
	end

	// read selects line up with the registered RAM outputs.
	always_ff @(posedge sys_clk) begin
		region_q <= region_data;
		lane_q   <= dmem_addr_i[1:0];
	end

	assign host_rdata_o = region_q ? lane_rdata
		: {{(`USBMEM_HOST_DW - `USBMEM_PMEM_DW){1'b0}}, prog_rdata};
	assign dmem_rdata_o = lane_eng_rdata[2'd3 - lane_q];  // offset 0 lives in lane 3.

endmodule

//--- logic/byte_sequencer.sv
// byte engine that runs the program held in program memory.
// fetch, decode and execute take one cycle each, with an 8-bit accumulator.
`include "usbmem_consts.svh"

module byte_sequencer (
	input  logic                       sys_clk,
	input  logic                       sys_rst,
	input  logic                       run_i,
	output logic                       halted_o,

	output logic [`USBMEM_PMEM_AW-1:0] pmem_addr_o,
	input  usbmem_pkg::insn_t          pmem_data_i,

	output logic [`USBMEM_DMEM_AW-1:0] dmem_addr_o,
	output logic                       dmem_we_o,
	output logic [`USBMEM_BYTE_W-1:0]  dmem_wdata_o,
	input  logic [`USBMEM_BYTE_W-1:0]  dmem_rdata_i
);

	usbmem_pkg::seq_state_e            state;
	logic [`USBMEM_PMEM_AW-1:0]        pc;
	usbmem_pkg::insn_t                 ir;
	logic [`USBMEM_BYTE_W-1:0]         acc;
	logic                              run_start;

	assign run_start = run_i & ((state == usbmem_pkg::IDLE) | (state == usbmem_pkg::HALTED));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// memory side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign pmem_addr_o  = pc;
	// operand address goes out in DECODE so the byte is back for EXECUTE.
	assign dmem_addr_o  = (state == usbmem_pkg::DECODE) ? pmem_data_i.field : ir.field;
	assign dmem_we_o    = (state == usbmem_pkg::EXECUTE) & (ir.opcode == usbmem_pkg::OP_ST);
	assign dmem_wdata_o = acc;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state    <= usbmem_pkg::IDLE;
			pc       <= '0;
			halted_o <= 1'b0;
		end else begin
			// flag rises the cycle after HALTED is entered and drops on restart.
			halted_o <= (state == usbmem_pkg::HALTED) & ~run_i;
			case (state)
				usbmem_pkg::IDLE, usbmem_pkg::HALTED: begin
					if (run_i) begin
						state <= usbmem_pkg::FETCH;
						pc    <= '0;  // every run starts at word 0.
					end
				end
				usbmem_pkg::FETCH: begin
					state <= usbmem_pkg::DECODE;
				end
				usbmem_pkg::DECODE: begin
					state <= usbmem_pkg::EXECUTE;
				end
				usbmem_pkg::EXECUTE: begin
					if (ir.opcode == usbmem_pkg::OP_HALT) begin
						state <= usbmem_pkg::HALTED;
					end else begin
						state <= usbmem_pkg::FETCH;
						pc    <= (ir.opcode == usbmem_pkg::OP_JMP)
							? ir.field[`USBMEM_PMEM_AW-1:0] : pc + 1'b1;
					end
				end
				default: begin
					state <= usbmem_pkg::IDLE;
				end
			endcase
		end
	end

	// datapath, the store itself happens in the RAM at the EXECUTE edge.
	always_ff @(posedge sys_clk) begin
		if (run_start) begin
			acc <= '0;
		end
		if (state == usbmem_pkg::DECODE) begin
			ir <= pmem_data_i;
		end
		if (state == usbmem_pkg::EXECUTE) begin
			case (ir.opcode)
				usbmem_pkg::OP_LDI: acc <= ir.field[`USBMEM_IMM_W-1:0];
				usbmem_pkg::OP_LD:  acc <= dmem_rdata_i;
				usbmem_pkg::OP_ADD: acc <= acc + dmem_rdata_i;  // wraps at 256.
				default:            acc <= acc;  // unknown opcodes behave as nop.
			endcase
		end
	end

endmodule

//--- logic/usb_mem_top.sv
// usb memory subsystem top level.
// shared RAM with the byte engine attached, host bus and run control exposed.
`include "usbmem_consts.svh"

module usb_mem_top (
	input  logic                       sys_clk,
	input  logic                       sys_rst,
	input  logic                       run_i,

	input  usbmem_pkg::host_req_t      host_req_i,
	output logic                       host_ack_o,
	output logic [`USBMEM_HOST_DW-1:0] host_rdata_o,

	output logic                       halted_o
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// engine side wiring
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	logic [`USBMEM_PMEM_AW-1:0] pmem_addr;
	usbmem_pkg::insn_t          pmem_data;
	logic [`USBMEM_DMEM_AW-1:0] dmem_addr;
	logic                       dmem_we;
	logic [`USBMEM_BYTE_W-1:0]  dmem_wdata;
	logic [`USBMEM_BYTE_W-1:0]  dmem_rdata;

	shared_ram u_shared_ram (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.host_req_i   (host_req_i),
		.host_ack_o   (host_ack_o),
		.host_rdata_o (host_rdata_o),
		.pmem_addr_i  (pmem_addr),
		.pmem_data_o  (pmem_data),
		.dmem_addr_i  (dmem_addr),
		.dmem_we_i    (dmem_we),
		.dmem_wdata_i (dmem_wdata),
		.dmem_rdata_o (dmem_rdata)
	);

	byte_sequencer u_byte_sequencer (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.run_i        (run_i),
		.halted_o     (halted_o),
		.pmem_addr_o  (pmem_addr),
		.pmem_data_i  (pmem_data),
		.dmem_addr_o  (dmem_addr),
		.dmem_we_o    (dmem_we),
		.dmem_wdata_o (dmem_wdata),
		.dmem_rdata_i (dmem_rdata)
	);

endmodule

//--- bench/usb_mem_assertions.sv
// protocol and reset assertions for the usb memory top level.
// host acknowledge timing, reset values and no engine writes while halted.
module usb_mem_assertions (
	input logic                  sys_clk,
	input logic                  sys_rst,
	input usbmem_pkg::host_req_t host_req_i,
	input logic                  host_ack_i,
	input logic                  halted_i,
	input logic                  dmem_we_i
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// host bus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	a_ack_single: assert property (@(posedge sys_clk) disable iff (sys_rst)
		host_ack_i |=> !host_ack_i)
		else $error("host acknowledge lasted more than one cycle");

	a_ack_after_stb: assert property (@(posedge sys_clk) disable iff (sys_rst)
		host_ack_i |-> $past(host_req_i.stb))
		else $error("host acknowledge without a strobe");

	// a new request is answered on the very next edge.
	a_ack_latency: assert property (@(posedge sys_clk) disable iff (sys_rst)
		$rose(host_req_i.stb) |=> host_ack_i)
		else $error("host acknowledge missing one cycle after the strobe");

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reset and engine
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	a_reset_values: assert property (@(posedge sys_clk)
		sys_rst |=> (!host_ack_i && !halted_i && !dmem_we_i))
		else $error("outputs not low after reset");

	a_no_write_halted: assert property (@(posedge sys_clk) disable iff (sys_rst)
		halted_i |=> !dmem_we_i)
		else $error("engine write right after halt");

endmodule

bind usb_mem_top usb_mem_assertions u_assertions (
	.sys_clk    (sys_clk),
	.sys_rst    (sys_rst),
	.host_req_i (host_req_i),
	.host_ack_i (host_ack_o),
	.halted_i   (halted_o),
	.dmem_we_i  (dmem_we)
);

//--- bench/usb_mem_tb.sv
// testbench for the usb memory subsystem.
// host bus traffic against a byte model, then engine programs run and read back.
`include "usbmem_consts.svh"

module usb_mem_tb;

	localparam int CYCLE_LIMIT = 4000;  // about 700 cycles of traffic, with a wide margin.

	logic                  sys_clk;
	logic                  sys_rst;
	logic                  run_i;
	usbmem_pkg::host_req_t host_req;
	logic                  host_ack;
	logic [31:0]           host_rdata;
	logic                  halted;

	logic [7:0]  dmem_model [0:4095];  // one entry per engine byte address.
	logic [15:0] pmem_model [0:1023];
	integer      seed = 21889;
	int          cycle_count = 0;

	usb_mem_top dut_i (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.run_i        (run_i),
		.host_req_i   (host_req),
		.host_ack_o   (host_ack),
		.host_rdata_o (host_rdata),
		.halted_o     (halted)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	always @(posedge sys_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the run went past %0d cycles", CYCLE_LIMIT);
			$display("=== FAIL ===");
			$fatal(1, "timeout");
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reporting and address helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("Error: %s expected 0x%08h actual 0x%08h", name, exp, act);
		$display("=== FAIL ===");
		$fatal(1, "readback mismatch");
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("=== FAIL ===");
		$fatal(1, "check failed");
	endtask

	function automatic logic [31:0] data_adr(input logic [9:0] w);
		return (32'h1 << `USBMEM_REGION_BIT) | {20'h0, w, 2'b00};
	endfunction

	function automatic logic [31:0] prog_adr(input logic [9:0] w);
		return {20'h0, w, 2'b00};
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// host bus model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic wait_ack();
		@(negedge sys_clk);
		while (!host_ack) @(negedge sys_clk);
	endtask

	task automatic host_write(input logic [31:0] adr, input logic [3:0] sel,
		input logic [31:0] wdata);
		logic [11:0] b;
		logic [31:0] d;
		logic [3:0]  s;
		d = wdata;
		s = sel;
		if (adr[`USBMEM_REGION_BIT]) begin
			for (int k = 0; k < 4; k++) begin
				b = {adr[11:2], 2'(k)};
				if (s[3]) dmem_model[b] = d[31:24];  // byte 4w sits in bits 31..24.
				d = d << 8;
				s = s << 1;
			end
		end else begin
			pmem_model[adr[11:2]] = wdata[15:0];
		end
		@(negedge sys_clk);
		host_req.stb   = 1'b1;
		host_req.we    = 1'b1;
		host_req.sel   = sel;
		host_req.adr   = adr;
		host_req.wdata = wdata;
		wait_ack();
		@(negedge sys_clk);
		host_req = '0;  // strobe is still seen at the edge that ends the acknowledge.
	endtask

	task automatic host_read(input logic [31:0] adr, output logic [31:0] rdata);
		@(negedge sys_clk);
		host_req.stb   = 1'b1;
		host_req.we    = 1'b0;
		host_req.sel   = 4'hf;
		host_req.adr   = adr;
		host_req.wdata = '0;
		wait_ack();
		rdata = host_rdata;
		@(negedge sys_clk);
		host_req = '0;
	endtask

	task automatic check_data_word(input logic [9:0] w);
		logic [31:0] exp;
		logic [31:0] act;
		exp = '0;
		for (int k = 0; k < 4; k++) begin
			exp = {exp[23:0], dmem_model[{w, 2'(k)}]};
		end
		host_read(data_adr(w), act);
		assert (act === exp) else report_mismatch("host_rdata_o", exp, act);
	endtask

	task automatic check_prog_word(input logic [9:0] w);
		logic [31:0] act;
		host_read(prog_adr(w), act);
		assert (act === {16'h0, pmem_model[w]})
			else report_mismatch("host_rdata_o", {16'h0, pmem_model[w]}, act);
	endtask

	task automatic load_insn(input logic [9:0] w, input usbmem_pkg::opcode_e op,
		input logic [11:0] field);
		host_write(prog_adr(w), 4'hf, {16'h0, op, field});
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// engine reference and run control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic model_run(output int n);
		logic [9:0]  pc;
		logic [7:0]  acc;
		logic [15:0] insn;
		logic        done;
		pc   = '0;
		acc  = '0;
		n    = 0;
		done = 1'b0;
		while (!done && n < 64) begin
			insn = pmem_model[pc];
			n++;
			pc = pc + 10'd1;
			case (insn[15:12])
				usbmem_pkg::OP_LDI:  acc = insn[7:0];
				usbmem_pkg::OP_LD:   acc = dmem_model[insn[11:0]];
				usbmem_pkg::OP_ST:   dmem_model[insn[11:0]] = acc;
				usbmem_pkg::OP_ADD:  acc = acc + dmem_model[insn[11:0]];
				usbmem_pkg::OP_JMP:  pc = insn[9:0];
				usbmem_pkg::OP_HALT: done = 1'b1;
				default:             ;
			endcase
		end
	endtask

	// one cycle pulse on run_i, then halted_o must come 3n+1 edges after the start edge.
	task automatic run_and_wait(input int n);
		int edges;
		@(negedge sys_clk);
		run_i = 1'b1;
		@(negedge sys_clk);
		run_i = 1'b0;
		edges = 1;
		assert (!halted) else report_failure("halted_o stayed high after the run started");
		while (!halted) begin
			@(negedge sys_clk);
			edges++;
		end
		assert (edges - 1 == 3 * n + 1) else report_failure($sformatf(
			"halted_o rose %0d cycles after the start instead of %0d", edges - 1, 3 * n + 1));
	endtask

	initial begin
		logic [31:0] r;
		int          n;
		sys_rst  = 1'b1;
		run_i    = 1'b0;
		host_req = '0;
		repeat (5) @(negedge sys_clk);
		sys_rst = 1'b0;

		// full words first so every later readback is defined.
		for (int i = 0; i < 40; i++) begin
			host_write(data_adr(10'(i)), 4'hf, $random(seed));
		end
		for (int i = 0; i < 60; i++) begin
			r = $random(seed);
			host_write(data_adr(10'(r % 40)), 4'($random(seed)), $random(seed));
		end
		for (int i = 0; i < 40; i++) begin
			check_data_word(10'(i));
		end

		for (int i = 512; i < 528; i++) begin
			host_write(prog_adr(10'(i)), 4'hf, $random(seed));
			check_prog_word(10'(i));
		end

		load_insn(10'd0, usbmem_pkg::OP_LDI, 12'h05a);
		load_insn(10'd1, usbmem_pkg::OP_ST, 12'h001);
		load_insn(10'd2, usbmem_pkg::OP_ST, 12'h006);
		load_insn(10'd3, usbmem_pkg::OP_LD, 12'h041);
		load_insn(10'd4, usbmem_pkg::OP_ADD, 12'h042);
		load_insn(10'd5, usbmem_pkg::OP_ST, 12'h045);
		load_insn(10'd6, usbmem_pkg::OP_HALT, 12'h000);
		model_run(n);
		run_and_wait(n);
		check_data_word(10'd0);
		check_data_word(10'd1);
		check_data_word(10'h10);
		check_data_word(10'h11);

		// the store at word 2 is jumped over, so byte 0x81 keeps its value.
		load_insn(10'd0, usbmem_pkg::OP_LDI, 12'h033);
		load_insn(10'd1, usbmem_pkg::OP_JMP, 12'h003);
		load_insn(10'd2, usbmem_pkg::OP_ST, 12'h081);
		load_insn(10'd3, usbmem_pkg::OP_ST, 12'h082);
		load_insn(10'd4, usbmem_pkg::OP_HALT, 12'h000);
		model_run(n);
		run_and_wait(n);
		check_data_word(10'h20);
		host_write(data_adr(10'h20), 4'b0010, $random(seed));
		check_data_word(10'h20);
		model_run(n);
		run_and_wait(n);
		check_data_word(10'h20);

		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+logic
logic/usbmem_pkg.sv
logic/dual_port_ram.sv
logic/shared_ram.sv
logic/byte_sequencer.sv
logic/usb_mem_top.sv
bench/usb_mem_assertions.sv
bench/usb_mem_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the usb memory testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f vlog.f --top-module usb_mem_tb
./obj_dir/Vusb_mem_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
	exit 1
fi
